/* filelist.f */
+incdir+src
src/csr_map_pkg.sv
src/csr_priv_pkg.sv
src/csr_access_unit.sv
src/csr_write_arbiter.sv
src/machine_csr_bank.sv
src/fp_csr_bank.sv
src/csr_file_top.sv
sim/csr_checker.sv
sim/csr_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the CSR file testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module csr_tb -f filelist.f --Mdir obj_dir -o csr_tb
	@out="$$(./obj_dir/csr_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* sim/csr_tb.sv */
// Testbench for the RV32 machine-mode CSR file
// One table row per clock cycle, inputs driven 1 ns after the rising edge
// Expected values follow the CSR rules, random data from a fixed-seed xorshift

`default_nettype none

`include "csr_cfg.svh"

module csr_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam csr_map_pkg::csr_op_e op_rw  = csr_map_pkg::CSR_OP_RW;
  localparam csr_map_pkg::csr_op_e op_rs  = csr_map_pkg::CSR_OP_RS;
  localparam csr_map_pkg::csr_op_e op_rc  = csr_map_pkg::CSR_OP_RC;
  localparam csr_map_pkg::csr_op_e op_rsi = csr_map_pkg::CSR_OP_RSI;
  localparam csr_priv_pkg::priv_e  priv_m = csr_priv_pkg::PRIV_M;
  localparam csr_priv_pkg::priv_e  priv_u = csr_priv_pkg::PRIV_U;
  localparam logic [1:0] ev_none = 2'd0;  // Pipeline event per row
  localparam logic [1:0] ev_trap = 2'd1;
  localparam logic [1:0] ev_mret = 2'd2;

  // DUT ports
  logic                 clk;
  logic                 reset_n;
  logic [11:0]          csr_addr;
  logic [`CSR_XLEN-1:0] csr_wdata;
  csr_map_pkg::csr_op_e csr_op;
  logic                 csr_we;
  csr_priv_pkg::priv_e  current_priv;
  logic                 trap_entry;
  logic [`CSR_XLEN-1:0] trap_pc;
  logic [4:0]           trap_cause;
  logic [`CSR_XLEN-1:0] trap_val;
  logic                 mret;
  logic                 fflags_we;
  logic [4:0]           fflags_in;
  logic [`CSR_XLEN-1:0] csr_rdata;
  logic                 illegal_csr;
  logic [`CSR_XLEN-1:0] trap_vector;
  logic [`CSR_XLEN-1:0] mepc_out;
  logic                 mstatus_mie;
  logic [1:0]           mpp_out;
  logic [2:0]           frm_out;
  logic [4:0]           fflags_out;

  // Checker side
  logic         chk_valid;
  logic [127:0] chk_name;  // Up to 16 characters
  logic [75:0]  chk_exp;   // Bit 75 set for a state check
  int           tests_run;
  int           tests_failed;

  // ====================
  // Stimulus table
  // ====================
  logic [127:0]         t_name [48];
  logic [11:0]          t_addr [48];
  csr_map_pkg::csr_op_e t_op   [48];
  logic [31:0]          t_data [48];  // Also trap_pc on trap rows
  logic                 t_we   [48];
  csr_priv_pkg::priv_e  t_priv [48];
  logic [1:0]           t_evt  [48];
  logic                 t_fwe  [48];
  logic [4:0]           t_fin  [48];
  logic [75:0]          t_exp  [48];
  int                   n_rows;
  logic [31:0]          rng_state;
  bit                   timed_out;

  csr_file_top csr_file_top_i (
    .clk, .reset_n, .csr_addr, .csr_wdata, .csr_op, .csr_we, .current_priv,
    .trap_entry, .trap_pc, .trap_cause, .trap_val, .mret, .fflags_we, .fflags_in,
    .csr_rdata, .illegal_csr, .trap_vector, .mepc_out, .mstatus_mie, .mpp_out,
    .frm_out, .fflags_out
  );

  csr_checker csr_checker_i (
    .clk, .valid(chk_valid), .name(chk_name), .expected(chk_exp),
    .csr_rdata, .illegal_csr, .trap_vector, .mepc_out, .mstatus_mie, .mpp_out,
    .frm_out, .fflags_out, .tests_run, .tests_failed
  );

  always #10 clk = ~clk;  // 20 ns period

  initial begin
    reset_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic draw_rand(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  function automatic logic [75:0] read_expect(input logic [31:0] rdata, input logic ill);
    return {1'b0, 42'b0, rdata, ill};
  endfunction

  // trap_vector, mepc_out, mstatus_mie, mpp_out, frm_out, fflags_out
  function automatic logic [75:0] state_expect(input logic [31:0] vec, input logic [31:0] epc,
                                               input logic mie, input logic [1:0] mpp,
                                               input logic [2:0] frm, input logic [4:0] ff);
    return {1'b1, vec, epc, mie, mpp, frm, ff};
  endfunction

  task automatic add_row(input logic [127:0] name, input logic [11:0] addr,
                         input csr_map_pkg::csr_op_e op, input logic [31:0] data,
                         input logic we, input csr_priv_pkg::priv_e priv,
                         input logic [1:0] evt, input logic fwe, input logic [4:0] fin,
                         input logic [75:0] exp);
    t_name[n_rows] = name;
    t_addr[n_rows] = addr;
    t_op[n_rows]   = op;
    t_data[n_rows] = data;
    t_we[n_rows]   = we;
    t_priv[n_rows] = priv;
    t_evt[n_rows]  = evt;
    t_fwe[n_rows]  = fwe;
    t_fin[n_rows]  = fin;
    t_exp[n_rows]  = exp;
    n_rows++;
  endtask

  // M-mode read, nothing else going on
  task automatic read_row(input logic [127:0] name, input logic [11:0] addr,
                          input logic [31:0] exp);
    add_row(name, addr, op_rs, 32'h0, 1'b0, priv_m, ev_none, 1'b0, 5'h0,
            read_expect(exp, 1'b0));
  endtask

  task automatic write_row(input logic [127:0] name, input logic [11:0] addr,
                           input csr_map_pkg::csr_op_e op, input logic [31:0] data,
                           input csr_priv_pkg::priv_e priv, input logic [31:0] exp,
                           input logic ill);
    add_row(name, addr, op, data, 1'b1, priv, ev_none, 1'b0, 5'h0, read_expect(exp, ill));
  endtask

  task automatic state_row(input logic [127:0] name, input logic [75:0] exp);
    add_row(name, 12'h000, op_rs, 32'h0, 1'b0, priv_m, ev_none, 1'b0, 5'h0, exp);
  endtask

  task automatic apply_row(input int i);
    csr_addr     = t_addr[i];
    csr_wdata    = t_data[i];
    csr_op       = t_op[i];
    csr_we       = t_we[i];
    current_priv = t_priv[i];
    trap_entry   = (t_evt[i] == ev_trap);
    mret         = (t_evt[i] == ev_mret);
    trap_pc      = t_data[i];
    trap_val     = ~t_data[i];  // Distinct from the PC
    fflags_we    = t_fwe[i];
    fflags_in    = t_fin[i];
    chk_name     = t_name[i];
    chk_exp      = t_exp[i];
    chk_valid    = 1'b1;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] mask;
    logic [31:0] scratch;  // Model of mscratch
    int          cycles;
    clk          = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    csr_op       = op_rs;
    csr_we       = 1'b0;
    current_priv = priv_m;
    trap_entry   = 1'b0;
    trap_pc      = '0;
    trap_cause   = csr_priv_pkg::CAUSE_ECALL_U;  // Code 8, only cause used
    trap_val     = '0;
    mret         = 1'b0;
    fflags_we    = 1'b0;
    fflags_in    = '0;
    chk_valid    = 1'b0;
    chk_name     = '0;
    chk_exp      = '0;
    n_rows       = 0;
    rng_state    = 32'd58046;
    timed_out    = 1'b0;

    // ====================
    // Table
    // ====================
    state_row("state_reset", state_expect(32'h0, 32'h0, 1'b0, 2'd3, 3'd0, 5'h0));
    read_row("rd_mstatus", 12'h300, 32'h0000_1800);
    read_row("rd_misa", 12'h301, 32'h4000_1129);
    read_row("rd_mimpid", 12'hF13, 32'h1);
    read_row("rd_mhartid", 12'hF14, 32'h0);
    read_row("rd_unknown", 12'h7C0, 32'h0);
    // Read-modify-write, old value comes back
    draw_rand(r);
    write_row("rw_mscratch", 12'h340, op_rw, r, priv_m, 32'h0, 1'b0);
    scratch = r;
    read_row("rd_mscratch", 12'h340, scratch);
    draw_rand(mask);
    write_row("rs_mscratch", 12'h340, op_rs, mask, priv_m, scratch, 1'b0);
    scratch = scratch | mask;
    draw_rand(mask);
    write_row("rc_mscratch", 12'h340, op_rc, mask, priv_m, scratch, 1'b0);
    scratch = scratch & ~mask;
    write_row("rsi_mscratch", 12'h340, op_rsi, 32'h15, priv_m, scratch, 1'b0);
    scratch = scratch | 32'h15;
    read_row("rd_mscratch2", 12'h340, scratch);
    write_row("wr_mtvec", 12'h305, op_rw, 32'h8000_0103, priv_m, 32'h0, 1'b0);
    read_row("rd_mtvec", 12'h305, 32'h8000_0100);  // Low two bits dropped
    // Illegal writes leave state alone
    draw_rand(r);
    write_row("wr_misa", 12'h301, op_rw, r, priv_m, 32'h4000_1129, 1'b1);
    read_row("rd_misa2", 12'h301, 32'h4000_1129);
    write_row("wr_mvendorid", 12'hF11, op_rw, r, priv_m, 32'h0, 1'b1);
    read_row("rd_mvendorid", 12'hF11, 32'h0);
    write_row("wr_unknown", 12'h7C0, op_rw, r, priv_m, 32'h0, 1'b1);
    write_row("wr_mscratch_u", 12'h340, op_rw, ~scratch, priv_u, scratch, 1'b1);
    read_row("rd_mscratch3", 12'h340, scratch);
    // Trap from U-mode, then MRET
    write_row("set_mie", 12'h300, op_rs, 32'h8, priv_m, 32'h0000_1800, 1'b0);
    read_row("rd_mstatus_mie", 12'h300, 32'h0000_1808);
    add_row("trap_u", 12'h300, op_rs, 32'h2468, 1'b0, priv_u, ev_trap, 1'b0, 5'h0,
            read_expect(32'h0000_1808, 1'b0));
    state_row("state_trap", state_expect(32'h8000_0100, 32'h2468, 1'b0, 2'd0, 3'd0, 5'h0));
    read_row("rd_mcause", 12'h342, 32'd8);
    read_row("rd_mtval", 12'h343, 32'hFFFF_DB97);
    read_row("rd_mstatus_trap", 12'h300, 32'h0000_0080);  // MPIE set, MPP = U
    add_row("mret", 12'h300, op_rs, 32'h0, 1'b0, priv_m, ev_mret, 1'b0, 5'h0,
            read_expect(32'h0000_0080, 1'b0));
    state_row("state_mret", state_expect(32'h8000_0100, 32'h2468, 1'b1, 2'd0, 3'd0, 5'h0));
    read_row("rd_mstatus_mret", 12'h300, 32'h0000_0088);
    // FPU flags, forwarding and fcsr priority
    add_row("fpu_acc1", 12'h001, op_rs, 32'h0, 1'b0, priv_m, ev_none, 1'b1, 5'h01,
            read_expect(32'h01, 1'b0));
    add_row("fpu_acc2", 12'h001, op_rs, 32'h0, 1'b0, priv_m, ev_none, 1'b1, 5'h04,
            read_expect(32'h05, 1'b0));
    read_row("rd_fflags", 12'h001, 32'h05);
    add_row("wr_fcsr", 12'h003, op_rw, 32'hA2, 1'b1, priv_m, ev_none, 1'b1, 5'h10,
            read_expect(32'h15, 1'b0));
    read_row("rd_fcsr", 12'h003, 32'hA2);  // frm 5, flags 2
    write_row("wr_frm", 12'h002, op_rw, 32'h3, priv_m, 32'h5, 1'b0);
    state_row("state_fp", state_expect(32'h8000_0100, 32'h2468, 1'b1, 2'd0, 3'd3, 5'h02));

    // Reset release, bounded
    cycles = 0;
    while (reset_n !== 1'b1 && cycles < 10) begin
      @(posedge clk);
      cycles++;
    end
    if (reset_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("Timeout: reset_n still low after %0d cycles", cycles);
    end else begin
      for (int i = 0; i < n_rows; i++) begin
        @(posedge clk);
        #1;
        apply_row(i);
      end
      @(posedge clk);
      #1;
      chk_valid = 1'b0;  // Last row already sampled
    end

    if (!timed_out && tests_run != n_rows) begin
      $display("Checker saw only %0d of %0d tests", tests_run, n_rows);
    end
    $display("Tests run %0d, failed %0d", tests_run, tests_failed);
    if (timed_out || tests_failed != 0 || tests_run != n_rows) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST OK");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/csr_checker.sv */
// Compares DUT outputs with the expected word of each table row
// Samples on the falling edge, well after the inputs have settled
// Bit 75 of the expected word selects a state check over a read check

`default_nettype none

`include "csr_cfg.svh"

module csr_checker (
  input  wire                  clk,
  input  wire                  valid,
  input  wire [127:0]          name,
  input  wire [75:0]           expected,
  input  wire [`CSR_XLEN-1:0]  csr_rdata,
  input  wire                  illegal_csr,
  input  wire [`CSR_XLEN-1:0]  trap_vector,
  input  wire [`CSR_XLEN-1:0]  mepc_out,
  input  wire                  mstatus_mie,
  input  wire [1:0]            mpp_out,
  input  wire [2:0]            frm_out,
  input  wire [4:0]            fflags_out,
  output int                   tests_run,
  output int                   tests_failed
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [74:0] actual;

  initial begin
    tests_run    = 0;
    tests_failed = 0;
  end

  // ====================
  // Per-test compare
  // ====================
  always @(negedge clk) begin
    if (valid) begin
      if (expected[75]) begin
        actual = {trap_vector, mepc_out, mstatus_mie, mpp_out, frm_out, fflags_out};
      end else begin
        actual = {42'b0, csr_rdata, illegal_csr};  // Read data, then illegal flag
      end
      tests_run = tests_run + 1;
      if (actual !== expected[74:0]) begin
        tests_failed = tests_failed + 1;
        $display("Mismatch %0s expected %h actual %h", name, expected[74:0], actual);
      end else begin
        $display("pass     %0s", name);
      end
    end
  end

endmodule

`default_nettype wire

/* src/csr_file_top.sv */
// Machine-mode CSR file for an RV32 core, no S-mode
// Reads are combinational, granted writes land on the next edge

`default_nettype none

`include "csr_cfg.svh"

module csr_file_top (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire [11:0]                   csr_addr,
  input  wire [`CSR_XLEN-1:0]          csr_wdata,
  input  wire csr_map_pkg::csr_op_e    csr_op,
  input  wire                          csr_we,
  input  wire csr_priv_pkg::priv_e     current_priv,
  input  wire                          trap_entry,
  input  wire [`CSR_XLEN-1:0]          trap_pc,
  input  wire [$bits(csr_priv_pkg::trap_cause_e)-1:0] trap_cause,
  input  wire [`CSR_XLEN-1:0]          trap_val,
  input  wire                          mret,
  input  wire                          fflags_we,
  input  wire [4:0]                    fflags_in,
  output logic [`CSR_XLEN-1:0]         csr_rdata,
  output logic                         illegal_csr,
  output logic [`CSR_XLEN-1:0]         trap_vector,
  output logic [`CSR_XLEN-1:0]         mepc_out,
  output logic                         mstatus_mie,
  output logic [1:0]                   mpp_out,
  output logic [2:0]                   frm_out,
  output logic [4:0]                   fflags_out
);

  // ====================
  // Internal nets
  // ====================
  logic [`CSR_XLEN-1:0]  csr_write_value;
  csr_priv_pkg::wr_src_e bus_src;  // Shared write bus
  logic [11:0]           bus_addr;
  logic [`CSR_XLEN-1:0]  bus_data;
  logic [`CSR_XLEN-1:0]  mstatus, mie, mtvec, mscratch;
  logic [`CSR_XLEN-1:0]  mepc, mcause, mtval, mip;
  logic [4:0]            fflags_view;

  csr_access_unit csr_access_unit_i (
    .csr_addr, .csr_wdata, .csr_op, .csr_we, .current_priv,
    .mstatus, .mie, .mtvec, .mscratch, .mepc, .mcause, .mtval, .mip,
    .fflags_view, .frm(frm_out), .csr_rdata, .csr_write_value, .illegal_csr
  );

  csr_write_arbiter csr_write_arbiter_i (
    .clk, .reset_n, .trap_entry, .mret, .csr_we, .illegal_csr,
    .csr_addr, .csr_write_value, .bus_src, .bus_addr, .bus_data
  );

  machine_csr_bank machine_csr_bank_i (
    .clk, .reset_n, .bus_src, .bus_addr, .bus_data, .current_priv,
    .trap_pc, .trap_cause, .trap_val,
    .mstatus, .mie, .mtvec, .mscratch, .mepc, .mcause, .mtval, .mip
  );

  fp_csr_bank fp_csr_bank_i (
    .clk, .reset_n, .bus_src, .bus_addr, .bus_data, .fflags_we, .fflags_in,
    .fflags(fflags_out), .fflags_view, .frm(frm_out)
  );

  // Core-facing views of machine state
  assign trap_vector = mtvec;  // Direct mode
  assign mepc_out    = mepc;
  assign mstatus_mie = mstatus[`CSR_MSTATUS_MIE_BIT];
  assign mpp_out     = mstatus[`CSR_MSTATUS_MPP_MSB:`CSR_MSTATUS_MPP_LSB];

endmodule

`default_nettype wire

/* src/fp_csr_bank.sv */
// fflags and frm with sticky accumulation of FPU exception flags
// A bus write to fflags or fcsr wins over accumulation in the same cycle

`default_nettype none

`include "csr_cfg.svh"

module fp_csr_bank (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire csr_priv_pkg::wr_src_e   bus_src,
  input  wire [11:0]                   bus_addr,
  input  wire [`CSR_XLEN-1:0]          bus_data,
  input  wire                          fflags_we,
  input  wire [4:0]                    fflags_in,
  output logic [4:0]                   fflags,       // Stored flags
  output logic [4:0]                   fflags_view,  // With same-cycle FPU flags
  output logic [2:0]                   frm
);

  logic bus_is_instr;
  logic bus_flags_write;

  assign bus_is_instr    = (bus_src == csr_priv_pkg::WR_INSTR);
  assign bus_flags_write = bus_is_instr && ((bus_addr == csr_map_pkg::CSR_FFLAGS) ||
                                            (bus_addr == csr_map_pkg::CSR_FCSR));

  // Forward writeback-stage flags to a CSR read in the same cycle
  assign fflags_view = fflags_we ? (fflags | fflags_in) : fflags;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags <= '0;
      frm    <= '0;  // RNE
    end else begin
      if (bus_flags_write) begin
        fflags <= bus_data[4:0];  // Same field for fflags and fcsr
      end else if (fflags_we) begin
        fflags <= fflags_view;    // Sticky OR
      end
      if (bus_is_instr && (bus_addr == csr_map_pkg::CSR_FRM)) begin
        frm <= bus_data[2:0];
      end else if (bus_is_instr && (bus_addr == csr_map_pkg::CSR_FCSR)) begin
        frm <= bus_data[7:5];
      end
    end
  end

endmodule

`default_nettype wire

/* src/machine_csr_bank.sv */
// Machine trap registers, written only through the shared bus
// Every trap targets M-mode; MRET always leaves MPP at U
// Only MIE, MPIE and MPP of mstatus hold state and the rest reads zero

`default_nettype none

`include "csr_cfg.svh"

module machine_csr_bank (
  input  wire                                          clk,
  input  wire                                          reset_n,
  input  wire csr_priv_pkg::wr_src_e                   bus_src,
  input  wire [11:0]                                   bus_addr,
  input  wire [`CSR_XLEN-1:0]                          bus_data,
  input  wire csr_priv_pkg::priv_e                     current_priv,
  input  wire [`CSR_XLEN-1:0]                          trap_pc,
  input  wire [$bits(csr_priv_pkg::trap_cause_e)-1:0]  trap_cause,
  input  wire [`CSR_XLEN-1:0]                          trap_val,
  output logic [`CSR_XLEN-1:0]                         mstatus,
  output logic [`CSR_XLEN-1:0]                         mie,
  output logic [`CSR_XLEN-1:0]                         mtvec,
  output logic [`CSR_XLEN-1:0]                         mscratch,
  output logic [`CSR_XLEN-1:0]                         mepc,
  output logic [`CSR_XLEN-1:0]                         mcause,
  output logic [`CSR_XLEN-1:0]                         mtval,
  output logic [`CSR_XLEN-1:0]                         mip
);

  // ====================
  // Register update
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mstatus  <= `CSR_MSTATUS_RESET;
      mie      <= '0;
      mtvec    <= '0;  // Handler at address 0
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      mip      <= '0;
    end else begin
      case (bus_src)
        csr_priv_pkg::WR_TRAP: begin
          mepc   <= trap_pc;
          mcause <= {{(`CSR_XLEN-$bits(trap_cause)){1'b0}}, trap_cause};  // Exceptions only
          mtval  <= trap_val;
          mstatus[`CSR_MSTATUS_MPIE_BIT] <= mstatus[`CSR_MSTATUS_MIE_BIT];
          mstatus[`CSR_MSTATUS_MIE_BIT]  <= 1'b0;  // Mask while in handler
          mstatus[`CSR_MSTATUS_MPP_MSB:`CSR_MSTATUS_MPP_LSB] <= current_priv;
        end
        csr_priv_pkg::WR_MRET: begin
          mstatus[`CSR_MSTATUS_MIE_BIT]  <= mstatus[`CSR_MSTATUS_MPIE_BIT];
          mstatus[`CSR_MSTATUS_MPIE_BIT] <= 1'b1;
          mstatus[`CSR_MSTATUS_MPP_MSB:`CSR_MSTATUS_MPP_LSB] <= csr_priv_pkg::PRIV_U;
        end
        csr_priv_pkg::WR_INSTR: begin
          case (bus_addr)
            csr_map_pkg::CSR_MSTATUS: begin
              // WARL with other fields held at zero
              mstatus[`CSR_MSTATUS_MIE_BIT]  <= bus_data[`CSR_MSTATUS_MIE_BIT];
              mstatus[`CSR_MSTATUS_MPIE_BIT] <= bus_data[`CSR_MSTATUS_MPIE_BIT];
              mstatus[`CSR_MSTATUS_MPP_MSB:`CSR_MSTATUS_MPP_LSB] <=
                bus_data[`CSR_MSTATUS_MPP_MSB:`CSR_MSTATUS_MPP_LSB];
            end
            csr_map_pkg::CSR_MIE:      mie      <= bus_data;
            csr_map_pkg::CSR_MTVEC:
              mtvec <= {bus_data[`CSR_XLEN-1:`CSR_MTVEC_ALIGN], {`CSR_MTVEC_ALIGN{1'b0}}};
            csr_map_pkg::CSR_MSCRATCH: mscratch <= bus_data;
            csr_map_pkg::CSR_MEPC:
              mepc <= {bus_data[`CSR_XLEN-1:`CSR_MEPC_ALIGN], {`CSR_MEPC_ALIGN{1'b0}}};
            csr_map_pkg::CSR_MCAUSE:   mcause   <= bus_data;
            csr_map_pkg::CSR_MTVAL:    mtval    <= bus_data;
            csr_map_pkg::CSR_MIP:      mip      <= bus_data;
            default: ;  // FP addresses belong to the other bank
          endcase
        end
        default: ;
      endcase
    end
  end

  // No S-mode exists, so a trap never records S in MPP
  a_trap_not_from_s: assert property (
    @(posedge clk) disable iff (!reset_n)
    (bus_src == csr_priv_pkg::WR_TRAP) |-> (current_priv != csr_priv_pkg::PRIV_S)
  );

endmodule

`default_nettype wire

/* src/csr_write_arbiter.sv */
// Fixed-priority owner select for the shared CSR write bus
// Requesters are single-cycle strobes; a loser is dropped, not queued
// Clock and reset serve the protocol assertion only

`default_nettype none

`include "csr_cfg.svh"

module csr_write_arbiter (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          trap_entry,
  input  wire                          mret,
  input  wire                          csr_we,
  input  wire                          illegal_csr,
  input  wire [11:0]                   csr_addr,
  input  wire [`CSR_XLEN-1:0]          csr_write_value,
  output csr_priv_pkg::wr_src_e        bus_src,
  output logic [11:0]                  bus_addr,
  output logic [`CSR_XLEN-1:0]         bus_data
);

  // ====================
  // Grant
  // ====================
  always_comb begin
    bus_addr = '0;
    bus_data = '0;
    if (trap_entry) begin
      bus_src = csr_priv_pkg::WR_TRAP;  // Trap data travels on its own ports
    end else if (mret) begin
      bus_src = csr_priv_pkg::WR_MRET;
    end else if (csr_we && !illegal_csr) begin
      bus_src  = csr_priv_pkg::WR_INSTR;
      bus_addr = csr_addr;
      bus_data = csr_write_value;
    end else begin
      bus_src = csr_priv_pkg::WR_NONE;  // Includes faulting writes
    end
  end

  // Trap and return come from different pipeline events
  a_trap_mret_exclusive: assert property (
    @(posedge clk) disable iff (!reset_n) !(trap_entry && mret)
  );

endmodule

`default_nettype wire

/* src/csr_access_unit.sv */
// Address decode, access check, read mux and read-modify-write value
// Purely combinational; illegal_csr is only raised on a write attempt
// fflags_view must already include same-cycle FPU forwarding

`default_nettype none

`include "csr_cfg.svh"

module csr_access_unit (
  input  wire [11:0]                csr_addr,
  input  wire [`CSR_XLEN-1:0]       csr_wdata,
  input  wire csr_map_pkg::csr_op_e csr_op,
  input  wire                       csr_we,
  input  wire csr_priv_pkg::priv_e  current_priv,
  input  wire [`CSR_XLEN-1:0]       mstatus,
  input  wire [`CSR_XLEN-1:0]       mie,
  input  wire [`CSR_XLEN-1:0]       mtvec,
  input  wire [`CSR_XLEN-1:0]       mscratch,
  input  wire [`CSR_XLEN-1:0]       mepc,
  input  wire [`CSR_XLEN-1:0]       mcause,
  input  wire [`CSR_XLEN-1:0]       mtval,
  input  wire [`CSR_XLEN-1:0]       mip,
  input  wire [4:0]                 fflags_view,
  input  wire [2:0]                 frm,
  output logic [`CSR_XLEN-1:0]      csr_rdata,
  output logic [`CSR_XLEN-1:0]      csr_write_value,
  output logic                      illegal_csr
);

  logic       csr_exists;
  logic [1:0] cur_level;  // Plain bits for the level compare

  // ====================
  // Read mux
  // ====================
  always_comb begin
    csr_exists = 1'b1;
    case (csr_addr)
      csr_map_pkg::CSR_FFLAGS:    csr_rdata = {{(`CSR_XLEN-5){1'b0}}, fflags_view};
      csr_map_pkg::CSR_FRM:       csr_rdata = {{(`CSR_XLEN-3){1'b0}}, frm};
      csr_map_pkg::CSR_FCSR:      csr_rdata = {{(`CSR_XLEN-8){1'b0}}, frm, fflags_view};
      csr_map_pkg::CSR_MSTATUS:   csr_rdata = mstatus;
      csr_map_pkg::CSR_MISA:      csr_rdata = `CSR_MISA_VALUE;
      csr_map_pkg::CSR_MIE:       csr_rdata = mie;
      csr_map_pkg::CSR_MTVEC:     csr_rdata = mtvec;
      csr_map_pkg::CSR_MSCRATCH:  csr_rdata = mscratch;
      csr_map_pkg::CSR_MEPC:      csr_rdata = mepc;
      csr_map_pkg::CSR_MCAUSE:    csr_rdata = mcause;
      csr_map_pkg::CSR_MTVAL:     csr_rdata = mtval;
      csr_map_pkg::CSR_MIP:       csr_rdata = mip;
      csr_map_pkg::CSR_MVENDORID: csr_rdata = '0;  // Non-commercial
      csr_map_pkg::CSR_MARCHID:   csr_rdata = '0;
      csr_map_pkg::CSR_MIMPID:    csr_rdata = `CSR_MIMPID_VALUE;
      csr_map_pkg::CSR_MHARTID:   csr_rdata = '0;  // Single hart
      default: begin
        csr_rdata  = '0;  // Unknown reads as zero
        csr_exists = 1'b0;
      end
    endcase
  end

  // Level compare against address bits 9:8 and read-only space at 11:10
  assign cur_level   = current_priv;
  assign illegal_csr = csr_we && (!csr_exists ||
                                  (cur_level < csr_addr[9:8]) ||
                                  (csr_addr[11:10] == 2'b11) ||
                                  (csr_addr == csr_map_pkg::CSR_MISA));

  // Value stored on the next edge if the write is granted
  always_comb begin
    case (csr_op)
      csr_map_pkg::CSR_OP_RW, csr_map_pkg::CSR_OP_RWI: csr_write_value = csr_wdata;
      csr_map_pkg::CSR_OP_RS, csr_map_pkg::CSR_OP_RSI: csr_write_value = csr_rdata | csr_wdata;
      csr_map_pkg::CSR_OP_RC, csr_map_pkg::CSR_OP_RCI: csr_write_value = csr_rdata & ~csr_wdata;
      default:                                         csr_write_value = csr_rdata;
    endcase
  end

endmodule

`default_nettype wire

/* src/csr_priv_pkg.sv */
// Privilege levels, trap causes and write bus sources
// S is kept in the level encoding only, no S-mode state exists

`default_nettype none

package csr_priv_pkg;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,  // Address encoding only
    PRIV_M = 2'd3
  } priv_e;

  // Synchronous exception codes, 5-bit field of mcause
  typedef enum logic [4:0] {
    CAUSE_INSTR_MISALIGN = 5'd0,
    CAUSE_INSTR_FAULT    = 5'd1,
    CAUSE_ILLEGAL_INSTR  = 5'd2,
    CAUSE_BREAKPOINT     = 5'd3,
    CAUSE_LOAD_MISALIGN  = 5'd4,
    CAUSE_LOAD_FAULT     = 5'd5,
    CAUSE_STORE_MISALIGN = 5'd6,
    CAUSE_STORE_FAULT    = 5'd7,
    CAUSE_ECALL_U        = 5'd8,
    CAUSE_ECALL_M        = 5'd11
  } trap_cause_e;

  // Owner of the shared write bus
  typedef enum logic [1:0] {
    WR_NONE  = 2'd0,
    WR_TRAP  = 2'd1,
    WR_MRET  = 2'd2,
    WR_INSTR = 2'd3
  } wr_src_e;

endpackage

`default_nettype wire

/* src/csr_map_pkg.sv */
// CSR address map and funct3 encodings of the CSR instructions
// Only machine and floating-point addresses are implemented

`default_nettype none

package csr_map_pkg;

  // ====================
  // Address map
  // ====================
  typedef enum logic [11:0] {
    CSR_FFLAGS    = 12'h001,  // FP exception flags
    CSR_FRM       = 12'h002,  // FP rounding mode
    CSR_FCSR      = 12'h003,  // frm and fflags together
    CSR_MSTATUS   = 12'h300,
    CSR_MISA      = 12'h301,  // Read-only here
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MIP       = 12'h344,
    CSR_MVENDORID = 12'hF11,  // Info block, read-only by encoding
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    CSR_OP_RW  = 3'b001,
    CSR_OP_RS  = 3'b010,
    CSR_OP_RC  = 3'b011,
    CSR_OP_RWI = 3'b101,  // Immediate forms carry zero-extended uimm
    CSR_OP_RSI = 3'b110,
    CSR_OP_RCI = 3'b111
  } csr_op_e;

endpackage

`default_nettype wire

/* src/csr_cfg.svh */
// Build constants for the RV32 machine-mode CSR file
// XLEN is fixed at 32 and the misa value assumes RV32IMAFD
// Field positions follow the privileged spec layout of mstatus

`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// ====================
// Datapath
// ====================
`define CSR_XLEN 32

// mstatus field positions
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_LSB  11
`define CSR_MSTATUS_MPP_MSB  12
`define CSR_MSTATUS_RESET    32'h0000_1800  // MPP = M, interrupts off

// Alignment, as count of low bits forced to zero
`define CSR_MTVEC_ALIGN 2  // Direct mode only
`define CSR_MEPC_ALIGN  1  // Compressed ISA allowed

// Hardwired identification
`define CSR_MISA_VALUE   32'h4000_1129  // MXL=1, I M A F D
`define CSR_MIMPID_VALUE 32'h0000_0001

`endif
